// File: hdl/os_pkg.sv
`default_nettype none

package os_pkg;

   localparam int SYMBOL_W     = 8;   // bits per 8b/10b symbol
   localparam int SYM_IDX_W    = 4;   // symbol index inside one ordered set
   localparam int TS_LEN       = 16;  // TS1 / TS2 length in symbols
   localparam int SHORT_OS_LEN = 4;   // SKP / EIOS length in symbols
   localparam int LANE_NUM_SYM = 2;   // lane number field of a training set

   localparam logic [SYMBOL_W-1:0] SYM_COM  = 8'hBC;  // K28.5 comma
   localparam logic [SYMBOL_W-1:0] SYM_PAD  = 8'hF7;  // K23.7
   localparam logic [SYMBOL_W-1:0] SYM_SKP  = 8'h1C;  // K28.0
   localparam logic [SYMBOL_W-1:0] SYM_EIDL = 8'h7C;  // K28.3
   localparam logic [SYMBOL_W-1:0] TS1_ID   = 8'h4A;  // D10.2
   localparam logic [SYMBOL_W-1:0] TS2_ID   = 8'h45;  // D5.2

   // opcode of the requested set, codes 4..7 all send idle data
   typedef enum logic [2:0] {
      OS_TS1  = 3'd0,
      OS_TS2  = 3'd1,
      OS_SKP  = 3'd2,
      OS_EIOS = 3'd3,
      OS_IDLE = 3'd4
   } os_type_e;

   // code 3 behaves like LANE_REV
   typedef enum logic [1:0] {
      LANE_PAD = 2'd0,
      LANE_SEQ = 2'd1,
      LANE_REV = 2'd2
   } lane_mode_e;

   typedef enum logic {
      SEQ_IDLE = 1'b0,
      SEQ_SEND = 1'b1
   } seq_state_e;

endpackage

`default_nettype wire

// File: hdl/os_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module os_sequencer
   import os_pkg::*;
#(
   parameter int SYMBOLS_PER_CLK = 1
) (
   input  logic                 pclk,
   input  logic                 reset_n,
   input  logic                 start,
   input  os_type_e             os_type,
   input  logic [7:0]           link_number,
   input  logic [2:0]           rate,
   input  logic                 loopback,
   input  lane_mode_e           lane_mode,
   output logic                 busy,
   output logic                 finish,
   output logic                 beat_valid,
   output logic [SYM_IDX_W-1:0] sym_base,
   output os_type_e             cur_type,
   output logic [7:0]           link_reg,
   output logic [2:0]           rate_reg,
   output logic                 loopback_reg,
   output lane_mode_e           lane_mode_reg
);

   // symbols per beat in an index one bit wider
   localparam logic [SYM_IDX_W:0] STEP = (SYM_IDX_W + 1)'(SYMBOLS_PER_CLK);

   seq_state_e           state;
   logic [SYM_IDX_W:0]   set_len;    // symbols in the current set
   logic [SYM_IDX_W:0]   next_base;
   logic                 accept;
   logic                 last_beat;

   assign accept = start && (state == SEQ_IDLE);  // start while busy is dropped

   always_comb begin
      case (cur_type)
         OS_TS1, OS_TS2:  set_len = (SYM_IDX_W + 1)'(TS_LEN);
         OS_SKP, OS_EIOS: set_len = (SYM_IDX_W + 1)'(SHORT_OS_LEN);
         default:         set_len = STEP;  // idle is a single beat
      endcase
   end

   assign next_base = {1'b0, sym_base} + STEP;
   assign last_beat = (state == SEQ_SEND) && (next_base >= set_len);

   always_ff @(posedge pclk or negedge reset_n) begin
      if (!reset_n) begin
         state    <= SEQ_IDLE;
         sym_base <= '0;
         cur_type <= OS_IDLE;
         finish   <= 1'b0;
      end else begin
         finish <= last_beat;  // lines up with the last registered beat
         case (state)
            SEQ_IDLE: begin
               if (accept) begin
                  state    <= SEQ_SEND;
                  sym_base <= '0;
                  cur_type <= os_type;
               end
            end
            SEQ_SEND: begin
               sym_base <= next_base[SYM_IDX_W-1:0];
               if (last_beat) begin
                  state <= SEQ_IDLE;
               end
            end
         endcase
      end
   end

   // captured request fields
   always_ff @(posedge pclk or negedge reset_n) begin
      if (!reset_n) begin
         link_reg      <= '0;
         rate_reg      <= '0;
         loopback_reg  <= 1'b0;
         lane_mode_reg <= LANE_PAD;
      end else if (accept) begin
         link_reg      <= link_number;
         rate_reg      <= rate;
         loopback_reg  <= loopback;
         lane_mode_reg <= lane_mode;
      end
   end

   assign busy       = (state == SEQ_SEND);  // rises at the accepting edge
   assign beat_valid = (state == SEQ_SEND);  // packer registers this beat next edge

endmodule

`default_nettype wire

// File: hdl/os_symbol_builder.sv
`timescale 1ns/1ps
`default_nettype none

module os_symbol_builder
   import os_pkg::*;
#(
   parameter int SYMBOLS_PER_CLK = 1
) (
   input  os_type_e                              cur_type,
   input  logic [SYM_IDX_W-1:0]                  sym_base,
   input  logic [7:0]                            link_reg,
   input  logic [2:0]                            rate_reg,
   input  logic                                  loopback_reg,
   output logic [SYMBOLS_PER_CLK*SYMBOL_W-1:0]   slot_byte,
   output logic [SYMBOLS_PER_CLK-1:0]            slot_k,
   output logic [SYMBOLS_PER_CLK-1:0]            slot_is_lane_num
);

   // fields shared by every symbol of a training set
   logic [SYMBOL_W-1:0] link_sym;
   logic                link_k;
   logic [SYMBOL_W-1:0] rate_byte;
   logic [SYMBOL_W-1:0] ctrl_byte;
   logic [SYMBOL_W-1:0] id_byte;

   assign link_sym  = (link_reg == 8'h00) ? SYM_PAD : link_reg;  // PAD when unassigned
   assign link_k    = (link_reg == 8'h00);
   assign ctrl_byte = loopback_reg ? 8'h04 : 8'h00;
   assign id_byte   = (cur_type == OS_TS2) ? TS2_ID : TS1_ID;

   always_comb begin
      case (rate_reg)
         3'd1:    rate_byte = 8'h02;
         3'd2:    rate_byte = 8'h04;
         3'd3:    rate_byte = 8'h08;
         3'd4:    rate_byte = 8'h10;
         default: rate_byte = 8'h20;
      endcase
   end

   for (genvar s = 0; s < SYMBOLS_PER_CLK; s++) begin : g_slot
      logic [SYM_IDX_W-1:0] idx;
      logic [SYMBOL_W-1:0]  sym_byte;
      logic                 sym_k;
      logic                 sym_lane;

      assign idx = sym_base + SYM_IDX_W'(s);  // symbol carried by this slot

      always_comb begin
         sym_byte = '0;
         sym_k    = 1'b0;
         sym_lane = 1'b0;
         case (cur_type)
            OS_TS1, OS_TS2: begin
               case (int'(idx))
                  0: begin
                     sym_byte = SYM_COM;
                     sym_k    = 1'b1;
                  end
                  1: begin
                     sym_byte = link_sym;
                     sym_k    = link_k;
                  end
                  LANE_NUM_SYM: begin
                     sym_byte = SYM_PAD;  // replaced per lane in the packer
                     sym_k    = 1'b1;
                     sym_lane = 1'b1;
                  end
                  3:       sym_byte = 8'h00;  // N_FTS
                  4:       sym_byte = rate_byte;
                  5:       sym_byte = ctrl_byte;
                  default: sym_byte = id_byte;
               endcase
            end
            OS_SKP: begin
               sym_byte = (idx == '0) ? SYM_COM : SYM_SKP;
               sym_k    = 1'b1;
            end
            OS_EIOS: begin
               sym_byte = (idx == '0) ? SYM_COM : SYM_EIDL;
               sym_k    = 1'b1;
            end
            default: begin
               sym_byte = '0;  // idle data
               sym_k    = 1'b0;
            end
         endcase
      end

      assign slot_byte[s*SYMBOL_W +: SYMBOL_W] = sym_byte;
      assign slot_k[s]                         = sym_k;
      assign slot_is_lane_num[s]               = sym_lane;
   end

endmodule

`default_nettype wire

// File: hdl/os_lane_packer.sv
`timescale 1ns/1ps
`default_nettype none

module os_lane_packer
   import os_pkg::*;
#(
   parameter int LANES           = 16,
   parameter int SYMBOLS_PER_CLK = 1
) (
   input  logic                                        pclk,
   input  logic                                        reset_n,
   input  logic                                        beat_valid,
   input  lane_mode_e                                  lane_mode_reg,
   input  logic [SYMBOLS_PER_CLK*SYMBOL_W-1:0]         slot_byte,
   input  logic [SYMBOLS_PER_CLK-1:0]                  slot_k,
   input  logic [SYMBOLS_PER_CLK-1:0]                  slot_is_lane_num,
   output logic [LANES*SYMBOLS_PER_CLK*SYMBOL_W-1:0]   os_data,
   output logic [LANES*SYMBOLS_PER_CLK-1:0]            data_k,
   output logic [LANES*SYMBOLS_PER_CLK-1:0]            data_valid
);

   localparam int NSYM = LANES * SYMBOLS_PER_CLK;  // symbols per beat over all lanes

   logic [NSYM*SYMBOL_W-1:0] nxt_data;
   logic [NSYM-1:0]          nxt_k;

   for (genvar l = 0; l < LANES; l++) begin : g_lane
      logic [SYMBOL_W-1:0] num_byte;
      logic                num_k;

      always_comb begin
         case (lane_mode_reg)
            LANE_PAD: begin
               num_byte = SYM_PAD;
               num_k    = 1'b1;
            end
            LANE_SEQ: begin
               num_byte = SYMBOL_W'(l);
               num_k    = 1'b0;
            end
            default: begin
               num_byte = SYMBOL_W'(LANES - 1 - l);  // reversed numbering
               num_k    = 1'b0;
            end
         endcase
      end

      // slot s of lane l sits at symbol position s*LANES+l
      for (genvar s = 0; s < SYMBOLS_PER_CLK; s++) begin : g_slot
         localparam int POS = s * LANES + l;

         assign nxt_data[POS*SYMBOL_W +: SYMBOL_W] =
            slot_is_lane_num[s] ? num_byte : slot_byte[s*SYMBOL_W +: SYMBOL_W];
         assign nxt_k[POS] = slot_is_lane_num[s] ? num_k : slot_k[s];
      end
   end

   always_ff @(posedge pclk or negedge reset_n) begin
      if (!reset_n) begin
         os_data    <= '0;
         data_k     <= '0;
         data_valid <= '0;
      end else if (beat_valid) begin
         os_data    <= nxt_data;
         data_k     <= nxt_k;
         data_valid <= '1;
      end else begin
         os_data    <= '0;  // quiet bus between sets
         data_k     <= '0;
         data_valid <= '0;
      end
   end

endmodule

`default_nettype wire

// File: hdl/os_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module os_gen_top
   import os_pkg::*;
#(
   parameter int LANES           = 16,  // 1 to 16
   parameter int SYMBOLS_PER_CLK = 1    // 1, 2 or 4
) (
   input  logic                                        pclk,
   input  logic                                        reset_n,
   input  logic                                        start,
   input  os_type_e                                    os_type,
   input  logic [7:0]                                  link_number,
   input  logic [2:0]                                  rate,
   input  logic                                        loopback,
   input  lane_mode_e                                  lane_mode,
   output logic                                        busy,
   output logic                                        finish,
   output logic [LANES*SYMBOLS_PER_CLK*SYMBOL_W-1:0]   os_data,
   output logic [LANES*SYMBOLS_PER_CLK-1:0]            data_k,
   output logic [LANES*SYMBOLS_PER_CLK-1:0]            data_valid
);

   logic                                beat_valid;
   logic [SYM_IDX_W-1:0]                sym_base;
   os_type_e                            cur_type;
   logic [7:0]                          link_reg;
   logic [2:0]                          rate_reg;
   logic                                loopback_reg;
   lane_mode_e                          lane_mode_reg;
   logic [SYMBOLS_PER_CLK*SYMBOL_W-1:0] slot_byte;
   logic [SYMBOLS_PER_CLK-1:0]          slot_k;
   logic [SYMBOLS_PER_CLK-1:0]          slot_is_lane_num;

   os_sequencer #(
      .SYMBOLS_PER_CLK (SYMBOLS_PER_CLK)
   ) u_sequencer (
      .pclk          (pclk),
      .reset_n       (reset_n),
      .start         (start),
      .os_type       (os_type),
      .link_number   (link_number),
      .rate          (rate),
      .loopback      (loopback),
      .lane_mode     (lane_mode),
      .busy          (busy),
      .finish        (finish),
      .beat_valid    (beat_valid),
      .sym_base      (sym_base),
      .cur_type      (cur_type),
      .link_reg      (link_reg),
      .rate_reg      (rate_reg),
      .loopback_reg  (loopback_reg),
      .lane_mode_reg (lane_mode_reg)
   );

   os_symbol_builder #(
      .SYMBOLS_PER_CLK (SYMBOLS_PER_CLK)
   ) u_symbol_builder (
      .cur_type         (cur_type),
      .sym_base         (sym_base),
      .link_reg         (link_reg),
      .rate_reg         (rate_reg),
      .loopback_reg     (loopback_reg),
      .slot_byte        (slot_byte),
      .slot_k           (slot_k),
      .slot_is_lane_num (slot_is_lane_num)
   );

   os_lane_packer #(
      .LANES           (LANES),
      .SYMBOLS_PER_CLK (SYMBOLS_PER_CLK)
   ) u_lane_packer (
      .pclk             (pclk),
      .reset_n          (reset_n),
      .beat_valid       (beat_valid),
      .lane_mode_reg    (lane_mode_reg),
      .slot_byte        (slot_byte),
      .slot_k           (slot_k),
      .slot_is_lane_num (slot_is_lane_num),
      .os_data          (os_data),
      .data_k           (data_k),
      .data_valid       (data_valid)
   );

endmodule

`default_nettype wire

// File: tb/os_gen_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module os_gen_asserts
   import os_pkg::*;
#(
   parameter int LANES           = 16,
   parameter int SYMBOLS_PER_CLK = 1
) (
   input logic                               pclk,
   input logic                               reset_n,
   input logic                               busy,
   input logic                               finish,
   input logic [LANES*SYMBOLS_PER_CLK-1:0]   data_k,
   input logic [LANES*SYMBOLS_PER_CLK-1:0]   data_valid
);

   int fail_count = 0;  // read by the testbench after each request

   finish_single_pulse: assert property (@(posedge pclk) disable iff (!reset_n)
      finish |=> !finish)
      else begin
         $error("finish stayed high for more than one cycle");
         fail_count++;
      end

   // the sequencer leaves SEND on the same edge that registers finish
   busy_fall_with_finish: assert property (@(posedge pclk) disable iff (!reset_n)
      $fell(busy) == $rose(finish))
      else begin
         $error("busy did not fall together with the rise of finish");
         fail_count++;
      end

   valid_only_when_busy: assert property (@(posedge pclk) disable iff (!reset_n)
      ((|data_valid) && !busy) |-> finish)
      else begin
         $error("data_valid high while idle outside the finish cycle");
         fail_count++;
      end

   k_only_when_valid: assert property (@(posedge pclk) disable iff (!reset_n)
      (data_k & ~data_valid) == '0)
      else begin
         $error("data_k set on a symbol slot that is not valid");
         fail_count++;
      end

endmodule

bind os_gen_top os_gen_asserts #(
   .LANES           (LANES),
   .SYMBOLS_PER_CLK (SYMBOLS_PER_CLK)
) u_asserts (
   .pclk       (pclk),
   .reset_n    (reset_n),
   .busy       (busy),
   .finish     (finish),
   .data_k     (data_k),
   .data_valid (data_valid)
);

`default_nettype wire

// File: tb/tb_os_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_os_gen
   import os_pkg::*;
();

   localparam int LANES      = 4;
   localparam int SPC        = 2;  // symbols per lane per beat
   localparam int NSYM       = LANES * SPC;
   localparam int MAX_BEATS  = TS_LEN;
   localparam int WAIT_LIMIT = 64;

   typedef struct packed {
      logic [2:0] kind;     // raw opcode, 4..7 send idle
      logic [7:0] link;
      logic [2:0] rate;
      logic       lb;
      logic [1:0] mode;     // raw lane mode, 3 acts like reversed
      logic       restart;  // pulse a second start while busy
   } req_t;

   logic                     pclk;
   logic                     reset_n;
   logic                     start;
   os_type_e                 os_type;
   logic [7:0]               link_number;
   logic [2:0]               rate;
   logic                     loopback;
   lane_mode_e               lane_mode;
   logic                     busy;
   logic                     finish;
   logic [NSYM*SYMBOL_W-1:0] os_data;
   logic [NSYM-1:0]          data_k;
   logic [NSYM-1:0]          data_valid;

   req_t                     reqs[$];
   logic [NSYM*SYMBOL_W-1:0] exp_data[MAX_BEATS];
   logic [NSYM-1:0]          exp_k[MAX_BEATS];
   int                       exp_beats;

   os_gen_top #(.LANES(LANES), .SYMBOLS_PER_CLK(SPC)) DUT (.*);

   always #20 pclk = ~pclk;  // 40 ns period

   task automatic abort_run();
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped at the first failing check");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("Error: %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_quiet_outputs();
      check_value("busy", busy, '0);
      check_value("finish", finish, '0);
      check_value("data_valid", data_valid, '0);
      check_value("data_k", data_k, '0);
      check_value("os_data", os_data, '0);
   endtask

   task automatic add_request(input logic [2:0] kind, input logic [7:0] link,
                              input logic [2:0] rt, input logic lb,
                              input logic [1:0] mode, input logic restart);
      req_t r;
      r = {kind, link, rt, lb, mode, restart};
      reqs.push_back(r);
   endtask

   // reference symbol for one lane, returned as {k, byte}
   function automatic logic [8:0] expected_symbol(input req_t r, input int idx, input int lane);
      logic [7:0] rate_byte;
      case (r.rate)
         3'd1:    rate_byte = 8'h02;
         3'd2:    rate_byte = 8'h04;
         3'd3:    rate_byte = 8'h08;
         3'd4:    rate_byte = 8'h10;
         default: rate_byte = 8'h20;
      endcase
      if (r.kind == 3'd2) return {1'b1, (idx == 0) ? SYM_COM : SYM_SKP};
      if (r.kind == 3'd3) return {1'b1, (idx == 0) ? SYM_COM : SYM_EIDL};
      if (r.kind > 3'd3) return 9'h000;
      if (idx == 0) return {1'b1, SYM_COM};
      if (idx == 1) return (r.link == 8'h00) ? {1'b1, SYM_PAD} : {1'b0, r.link};
      if (idx == 2) begin
         if (r.mode == 2'd0) return {1'b1, SYM_PAD};
         if (r.mode == 2'd1) return {1'b0, 8'(lane)};
         return {1'b0, 8'(LANES - 1 - lane)};
      end
      if (idx == 3) return 9'h000;  // N_FTS
      if (idx == 4) return {1'b0, rate_byte};
      if (idx == 5) return {1'b0, r.lb ? 8'h04 : 8'h00};
      return {1'b0, (r.kind == 3'd1) ? TS2_ID : TS1_ID};
   endfunction

   task automatic build_expected(input req_t r);
      logic [8:0] sym;
      if (r.kind <= 3'd1) exp_beats = TS_LEN / SPC;
      else if (r.kind <= 3'd3) exp_beats = SHORT_OS_LEN / SPC;
      else exp_beats = 1;
      for (int k = 0; k < exp_beats; k++) begin
         for (int s = 0; s < SPC; s++) begin
            for (int l = 0; l < LANES; l++) begin
               sym = expected_symbol(r, k * SPC + s, l);
               exp_data[k][(s*LANES+l)*SYMBOL_W +: SYMBOL_W] = sym[7:0];
               exp_k[k][s*LANES+l] = sym[8];
            end
         end
      end
   endtask

   task automatic wait_until_idle();
      int cycles;
      cycles = 0;
      while (busy !== 1'b0) begin
         @(negedge pclk);
         cycles++;
         assert (cycles < WAIT_LIMIT) else begin
            $display("timed out waiting for busy to fall");
            abort_run();
         end
      end
   endtask

   task automatic run_request(input req_t r, input int num);
      int beats;
      int busy_cycles;
      int cycles;
      bit done;
      build_expected(r);
      wait_until_idle();
      @(posedge pclk);
      start       <= 1'b1;
      os_type     <= os_type_e'(r.kind);
      link_number <= r.link;
      rate        <= r.rate;
      loopback    <= r.lb;
      lane_mode   <= lane_mode_e'(r.mode);
      @(posedge pclk);  // request taken at this edge
      start <= 1'b0;
      beats       = 0;
      busy_cycles = 0;
      cycles      = 0;
      done        = 1'b0;
      while (!done) begin
         @(negedge pclk);
         if (busy) busy_cycles++;
         if (data_valid != '0) begin
            assert (beats < exp_beats) else begin
               $display("request %0d sent more beats than expected", num);
               abort_run();
            end
            check_value("data_valid", data_valid, {NSYM{1'b1}});
            check_value($sformatf("os_data beat %0d", beats), os_data, exp_data[beats]);
            check_value($sformatf("data_k beat %0d", beats), data_k, exp_k[beats]);
            beats++;
         end else begin
            check_value("os_data", os_data, '0);
         end
         if (finish) begin
            done = 1'b1;
            assert (beats == exp_beats && busy_cycles == exp_beats) else begin
               $display("request %0d gave %0d beats and %0d busy cycles, %0d expected",
                        num, beats, busy_cycles, exp_beats);
               abort_run();
            end
         end
         @(posedge pclk);
         if (r.restart && cycles == 0) begin
            start       <= 1'b1;  // must be dropped, the TS1 keeps going
            os_type     <= OS_SKP;
            link_number <= 8'hA5;
            lane_mode   <= LANE_PAD;
         end else begin
            start <= 1'b0;
         end
         cycles++;
         assert (cycles < WAIT_LIMIT) else begin
            $display("timed out waiting for finish of request %0d", num);
            abort_run();
         end
      end
      @(negedge pclk);
      check_quiet_outputs();
      assert (DUT.u_asserts.fail_count == 0) else begin
         $display("a protocol assertion fired during request %0d", num);
         abort_run();
      end
   endtask

   initial begin
      int gap;
      void'($urandom(32'h5c109277));
      pclk        = 1'b0;
      reset_n     = 1'b0;
      start       = 1'b0;
      os_type     = OS_TS1;
      link_number = 8'h00;
      rate        = 3'd0;
      loopback    = 1'b0;
      lane_mode   = LANE_PAD;
      // kind  link   rate  lb    mode  restart
      add_request(3'd0, 8'h01, 3'd1, 1'b0, 2'd1, 1'b0);
      add_request(3'd0, 8'h03, 3'd2, 1'b1, 2'd2, 1'b0);
      add_request(3'd0, 8'h07, 3'd3, 1'b0, 2'd1, 1'b0);
      add_request(3'd0, 8'h10, 3'd4, 1'b1, 2'd3, 1'b0);
      add_request(3'd0, 8'h22, 3'd6, 1'b0, 2'd2, 1'b0);
      add_request(3'd1, 8'h00, 3'd2, 1'b0, 2'd0, 1'b0);
      add_request(3'd1, 8'h00, 3'd0, 1'b1, 2'd0, 1'b0);
      add_request(3'd2, 8'h05, 3'd1, 1'b0, 2'd1, 1'b0);
      add_request(3'd3, 8'h05, 3'd1, 1'b0, 2'd2, 1'b0);
      add_request(3'd4, 8'h05, 3'd1, 1'b0, 2'd1, 1'b0);
      add_request(3'd7, 8'h00, 3'd0, 1'b1, 2'd0, 1'b0);
      add_request(3'd0, 8'h09, 3'd3, 1'b0, 2'd1, 1'b1);
      add_request(3'd2, 8'h00, 3'd0, 1'b0, 2'd0, 1'b0);
      repeat (16) @(posedge pclk);
      reset_n <= 1'b1;
      @(negedge pclk);
      check_quiet_outputs();
      foreach (reqs[i]) begin
         gap = $urandom % 4;  // idle cycles before the next request
         repeat (gap) @(posedge pclk);
         run_request(reqs[i], i);
      end
      @(negedge pclk);
      if (DUT.u_asserts.fail_count == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         $display("protocol assertions fired %0d times", DUT.u_asserts.fail_count);
         abort_run();
      end
   end

endmodule

`default_nettype wire

// File: all.f
hdl/os_pkg.sv
hdl/os_sequencer.sv
hdl/os_symbol_builder.sv
hdl/os_lane_packer.sv
hdl/os_gen_top.sv
tb/os_gen_asserts.sv
tb/tb_os_gen.sv

// File: Bender.yml
package:
  name: os_gen

sources:
  - files:
      - hdl/os_pkg.sv
      - hdl/os_sequencer.sv
      - hdl/os_symbol_builder.sv
      - hdl/os_lane_packer.sv
      - hdl/os_gen_top.sv

  - target: test
    files:
      - tb/os_gen_asserts.sv
      - tb/tb_os_gen.sv
